// File: hdl/aprPkg.sv
package aprPkg;

  localparam int WordBits = 36;
  localparam int NumFlags = 8;
  localparam int FmDepth = 128;
  localparam int FmAdrBits = $clog2(FmDepth);

  // Bus word, bit 0 is the most significant
  typedef logic [0:WordBits-1] ebusWordT;

  // Field order matches bus bits 6 through 13
  typedef struct packed {
    logic sbusErr;
    logic nxmErr;
    logic ioPageFail;
    logic mbParErr;
    logic cDirParErr;
    logic sAdrParErr;
    logic pwrFail;
    logic sweepDone;
  } flagVecT;

  // Conditions-out control sent with a bus word
  typedef struct packed {
    logic apply;
    logic selSet;
    logic selClr;
    logic selEn;
    logic selDis;
  } conoCtlT;

  typedef enum logic [2:0] {
    fromAc          = 3'd0,
    fromAcPlus1     = 3'd1,
    fromXr          = 3'd2,
    fromVma         = 3'd3,
    fromAcPlus2     = 3'd4,
    fromAcPlus3     = 3'd5,
    fromAcPlusMagic = 3'd6,
    fromMagic       = 3'd7
  } fmSelT;

  typedef struct packed {
    logic [2:0] block;
    logic [3:0] adr;
  } fmAdrT;

  typedef struct packed {
    logic [2:0] current;
    logic [2:0] previous;
  } acBlocksT;

  // Diagnostic readback pages
  typedef enum logic [2:0] {
    pgFlags   = 3'd0,
    pgEnables = 3'd1,
    pgBlocks  = 3'd2,
    pgFmAdr   = 3'd3,
    pgSummary = 3'd4
  } diagSelT;

endpackage

// File: hdl/aprFlags.sv
`timescale 1ns/1ps

module aprFlags (
  input  logic             clk,
  input  logic             reset,
  input  aprPkg::conoCtlT  conoCtl,
  input  aprPkg::ebusWordT ebusData,
  input  aprPkg::flagVecT  events,
  input  logic             sweepBusy,
  output aprPkg::flagVecT  flags,
  output aprPkg::flagVecT  enables,
  output logic             interrupt,
  output logic             anyEboxErr
);
  import aprPkg::*;

  logic [NumFlags-1:0] mask;
  logic [NumFlags-1:0] setMask;
  logic [NumFlags-1:0] clrMask;
  logic [NumFlags-1:0] enMask;
  logic [NumFlags-1:0] disMask;
  flagVecT             evt;
  flagVecT             flagsNext;
  flagVecT             enablesNext;
  logic                sweepBusyQ;

  // Bus bits 6..13 select which flags a CONO touches
  always_comb begin
    mask = conoCtl.apply ? ebusData[6:13] : '0;
    setMask = conoCtl.selSet ? mask : '0;
    clrMask = conoCtl.selClr ? mask : '0;
    enMask = conoCtl.selEn ? mask : '0;
    disMask = conoCtl.selDis ? mask : '0;
  end

  // Sweep done comes from the falling edge of sweepBusy, not the event input
  always_comb begin
    evt = events;
    evt.sweepDone = sweepBusyQ & ~sweepBusy;
  end

  // Clear first so that set and enable win
  always_comb begin
    flagsNext = flagVecT'((flags & ~clrMask) | setMask | evt);
    enablesNext = flagVecT'((enables & ~disMask) | enMask);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
      enables <= '0;
      sweepBusyQ <= 1'b0;
      anyEboxErr <= 1'b0;
    end else begin
      flags <= flagsNext;
      enables <= enablesNext;
      sweepBusyQ <= sweepBusy;
      // Summary tracks the new flag values, not the old ones
      anyEboxErr <= flagsNext.nxmErr | flagsNext.mbParErr | flagsNext.sAdrParErr;
    end
  end

  assign interrupt = |(flags & enables);

endmodule

// File: hdl/fmAddress.sv
`timescale 1ns/1ps

module fmAddress (
  input  logic             clk,
  input  logic             reset,
  input  aprPkg::ebusWordT ebusData,
  input  logic             loadBlocks,
  input  logic             loadVmaContext,
  input  logic             xrPrevious,
  input  logic             vmaPrevEn,
  input  logic [3:0]       ac,
  input  logic [3:0]       xr,
  input  logic [3:0]       vmaLow,
  input  logic [0:8]       magic,
  input  aprPkg::fmSelT    fmSel,
  output aprPkg::fmAdrT    fmAdr,
  output aprPkg::acBlocksT blocks
);
  import aprPkg::*;

  logic [2:0] vmaBlock;
  logic [2:0] xrBlock;
  logic [3:0] acPlus1;
  logic [3:0] acPlus2;
  logic [3:0] acPlus3;
  logic [3:0] acPlusMagic;

  // AC block registers, loaded from a DATAO
  always_ff @(posedge clk) begin
    if (reset) begin
      blocks <= '0;
      vmaBlock <= 3'd0;
    end else begin
      if (loadBlocks) begin
        blocks.current <= ebusData[6:8];
        blocks.previous <= ebusData[9:11];
      end
      if (loadVmaContext) begin
        vmaBlock <= vmaPrevEn ? blocks.previous : blocks.current;
      end
    end
  end

  // All offsets wrap within the sixteen-word block
  always_comb begin
    acPlus1 = ac + 4'd1;
    acPlus2 = ac + 4'd2;
    acPlus3 = ac + 4'd3;
    acPlusMagic = ac + magic[5:8];
    xrBlock = xrPrevious ? blocks.previous : blocks.current;
  end

  always_comb begin
    fmAdr.block = blocks.current;
    fmAdr.adr = ac;
    case (fmSel)
      fromAc: begin
        fmAdr.adr = ac;
      end
      fromAcPlus1: begin
        fmAdr.adr = acPlus1;
      end
      fromXr: begin
        fmAdr.block = xrBlock;
        fmAdr.adr = xr;
      end
      fromVma: begin
        fmAdr.block = vmaBlock;
        fmAdr.adr = vmaLow;
      end
      fromAcPlus2: begin
        fmAdr.adr = acPlus2;
      end
      fromAcPlus3: begin
        fmAdr.adr = acPlus3;
      end
      fromAcPlusMagic: begin
        fmAdr.adr = acPlusMagic;
      end
      fromMagic: begin
        // Microcode names the block and the word directly
        fmAdr.block = magic[2:4];
        fmAdr.adr = magic[5:8];
      end
      default: begin
        fmAdr.adr = ac;
      end
    endcase
  end

endmodule

// File: hdl/fmParity.sv
`timescale 1ns/1ps

module fmParity (
  input  logic          clk,
  input  aprPkg::fmAdrT fmAdr,
  input  logic          fmWrite,
  input  logic          arExtended,
  input  logic          arParOdd,
  output logic          fmExtended,
  output logic          fmBit36
);
  import aprPkg::*;

  // Per word: extension bit, then parity XOR extension
  logic [1:0]           store [FmDepth];
  logic [FmAdrBits-1:0] idx;
  logic                 xorBit;

  assign idx = fmAdr;

  always_ff @(posedge clk) begin
    if (fmWrite) begin
      store[idx] <= {arExtended, arParOdd ^ arExtended};
    end
  end

  assign fmExtended = store[idx][1];
  assign xorBit = store[idx][0];

  // Undo the write-side XOR to recover the parity bit
  assign fmBit36 = xorBit ^ fmExtended;

endmodule

// File: hdl/aprDiag.sv
`timescale 1ns/1ps

module aprDiag (
  input  logic             diagRead,
  input  aprPkg::diagSelT  diagSel,
  input  aprPkg::flagVecT  flags,
  input  aprPkg::flagVecT  enables,
  input  aprPkg::acBlocksT blocks,
  input  aprPkg::fmAdrT    fmAdr,
  input  logic             interrupt,
  input  logic             anyEboxErr,
  output aprPkg::ebusWordT diagData
);
  import aprPkg::*;

  // Idle bus reads as zero so other boards can OR onto it
  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        pgFlags: begin
          diagData[6:13] = flags;
        end
        pgEnables: begin
          diagData[6:13] = enables;
        end
        pgBlocks: begin
          diagData[6:8] = blocks.current;
          diagData[9:11] = blocks.previous;
        end
        pgFmAdr: begin
          diagData[6:8] = fmAdr.block;
          diagData[9:12] = fmAdr.adr;
        end
        pgSummary: begin
          diagData[14] = interrupt;
          diagData[15] = anyEboxErr;
        end
        default: begin
          diagData = '0;
        end
      endcase
    end
  end

endmodule

// File: hdl/aprTop.sv
`timescale 1ns/1ps

module aprTop (
  input  logic             clk,
  input  logic             reset,
  input  aprPkg::conoCtlT  conoCtl,
  input  aprPkg::ebusWordT ebusData,
  input  aprPkg::flagVecT  events,
  input  logic             sweepBusy,
  input  logic [3:0]       ac,
  input  logic [3:0]       xr,
  input  logic [3:0]       vmaLow,
  input  logic [0:8]       magic,
  input  aprPkg::fmSelT    fmSel,
  input  logic             loadBlocks,
  input  logic             loadVmaContext,
  input  logic             xrPrevious,
  input  logic             vmaPrevEn,
  input  logic             fmWrite,
  input  logic             arExtended,
  input  logic             arParOdd,
  input  logic             diagRead,
  input  aprPkg::diagSelT  diagSel,
  output logic             interrupt,
  output logic             anyEboxErr,
  output aprPkg::fmAdrT    fmAdr,
  output logic             fmExtended,
  output logic             fmBit36,
  output aprPkg::ebusWordT diagData
);
  import aprPkg::*;

  flagVecT  flags;
  flagVecT  enables;
  acBlocksT blocks;

  aprFlags u_flags (
    .clk       (clk),
    .reset     (reset),
    .conoCtl   (conoCtl),
    .ebusData  (ebusData),
    .events    (events),
    .sweepBusy (sweepBusy),
    .flags     (flags),
    .enables   (enables),
    .interrupt (interrupt),
    .anyEboxErr(anyEboxErr)
  );

  fmAddress u_fmAddress (
    .clk           (clk),
    .reset         (reset),
    .ebusData      (ebusData),
    .loadBlocks    (loadBlocks),
    .loadVmaContext(loadVmaContext),
    .xrPrevious    (xrPrevious),
    .vmaPrevEn     (vmaPrevEn),
    .ac            (ac),
    .xr            (xr),
    .vmaLow        (vmaLow),
    .magic         (magic),
    .fmSel         (fmSel),
    .fmAdr         (fmAdr),
    .blocks        (blocks)
  );

  fmParity u_fmParity (
    .clk       (clk),
    .fmAdr     (fmAdr),
    .fmWrite   (fmWrite),
    .arExtended(arExtended),
    .arParOdd  (arParOdd),
    .fmExtended(fmExtended),
    .fmBit36   (fmBit36)
  );

  aprDiag u_diag (
    .diagRead  (diagRead),
    .diagSel   (diagSel),
    .flags     (flags),
    .enables   (enables),
    .blocks    (blocks),
    .fmAdr     (fmAdr),
    .interrupt (interrupt),
    .anyEboxErr(anyEboxErr),
    .diagData  (diagData)
  );

endmodule

// File: verif/aprFlags_chk.sv
`timescale 1ns/1ps

module aprFlagsChk (
  input logic            clk,
  input logic            reset,
  input aprPkg::conoCtlT conoCtl,
  input aprPkg::flagVecT events,
  input logic            sweepBusy,
  input aprPkg::flagVecT flags,
  input aprPkg::flagVecT enables,
  input logic            interrupt
);
  import aprPkg::*;

  int failures = 0;
  logic [NumFlags-1:0] evtMask;

  // sweepDone has no event of its own
  assign evtMask = events & {{(NumFlags-1){1'b1}}, 1'b0};

  resetClears: assert property (@(posedge clk)
    reset |=> (flags == '0) && (enables == '0))
  else begin
    $error("flags or enables still set the cycle after reset");
    failures++;
  end

  // A new request follows a CONO, an event or the end of a sweep
  irqNeedsSource: assert property (@(posedge clk) disable iff (reset)
    $rose(interrupt) |-> $past(conoCtl.apply || (evtMask != '0))
                         || ($past(sweepBusy, 2) && !$past(sweepBusy)))
  else begin
    $error("interrupt rose with no CONO, event or sweep end on the edge before");
    failures++;
  end

  eventSetsFlag: assert property (@(posedge clk) disable iff (reset)
    (evtMask != '0) |=> ((flags & $past(evtMask)) == $past(evtMask)))
  else begin
    $error("event pulse did not set its flag");
    failures++;
  end

endmodule

bind aprFlags aprFlagsChk u_chk (
  .clk      (clk),
  .reset    (reset),
  .conoCtl  (conoCtl),
  .events   (events),
  .sweepBusy(sweepBusy),
  .flags    (flags),
  .enables  (enables),
  .interrupt(interrupt)
);

// File: verif/aprTb.sv
`timescale 1ns/1ps

module aprTb;
  import aprPkg::*;

  // Full run is roughly 500 cycles, so this leaves about four times headroom
  localparam int MaxCycles = 2000;
  localparam logic [31:0] Seed = 32'h9d4d7e28;

  logic       clk;
  logic       reset;
  conoCtlT    conoCtl;
  ebusWordT   ebusData;
  flagVecT    events;
  logic       sweepBusy;
  logic [3:0] ac;
  logic [3:0] xr;
  logic [3:0] vmaLow;
  logic [0:8] magic;
  fmSelT      fmSel;
  logic       loadBlocks;
  logic       loadVmaContext;
  logic       xrPrevious;
  logic       vmaPrevEn;
  logic       fmWrite;
  logic       arExtended;
  logic       arParOdd;
  logic       diagRead;
  diagSelT    diagSel;
  logic       interrupt;
  logic       anyEboxErr;
  fmAdrT      fmAdr;
  logic       fmExtended;
  logic       fmBit36;
  ebusWordT   diagData;

  int wordErrors = 0;
  int flagErrors = 0;
  int adrErrors = 0;
  int bitErrors = 0;
  int cycles = 0;

  // Reference state kept from the flag and block rules
  flagVecT    expFlags = '0;
  flagVecT    expEnables = '0;
  logic [2:0] expCur = '0;
  logic [2:0] expPrev = '0;
  logic [2:0] expVma = '0;

  aprTop u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic checkWord(string name, ebusWordT exp, ebusWordT act);
    if (act !== exp) begin
      wordErrors++;
      $display("** Error %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic checkFmAdr(string name, fmAdrT exp, fmAdrT act);
    if (act !== exp) begin
      adrErrors++;
      $display("** Error %s: expected %0d:%0d, got %0d:%0d", name, exp.block, exp.adr,
               act.block, act.adr);
    end
  endtask

  task automatic checkBit(string name, logic exp, logic act);
    if (act !== exp) begin
      bitErrors++;
      $display("** Error %s: expected %b, got %b", name, exp, act);
    end
  endtask

  task automatic readPage(diagSelT page, output ebusWordT w);
    @(posedge clk);
    diagRead <= 1'b1;
    diagSel <= page;
    @(negedge clk);
    w = diagData;
  endtask

  task automatic checkFlags(string name, flagVecT exp, diagSelT page);
    ebusWordT w;
    flagVecT  act;
    readPage(page, w);
    act = w[6:13];
    if (act !== exp) begin
      flagErrors++;
      $display("** Error %s: expected %b, got %b", name, exp, act);
    end
  endtask

  function automatic flagVecT applyRule(flagVecT cur, logic up, logic down, flagVecT m);
    flagVecT r;
    r = cur;
    if (down)
      r = flagVecT'(r & ~m);
    if (up)
      r = flagVecT'(r | m);
    return r;
  endfunction

  task automatic cono(conoCtlT ctl, flagVecT m);
    ebusWordT w;
    w = '0;
    w[6:13] = m;
    @(posedge clk);
    conoCtl <= ctl;
    ebusData <= w;
    @(posedge clk);
    conoCtl <= '0;
    ebusData <= '0;
    if (ctl.apply) begin
      expFlags = applyRule(expFlags, ctl.selSet, ctl.selClr, m);
      expEnables = applyRule(expEnables, ctl.selEn, ctl.selDis, m);
    end
  endtask

  task automatic pulseEvents(flagVecT e);
    @(posedge clk);
    events <= e;
    @(posedge clk);
    events <= '0;
    // The event input cannot set sweepDone
    e.sweepDone = 1'b0;
    expFlags = flagVecT'(expFlags | e);
  endtask

  task automatic loadBlockRegs(logic [2:0] cur, logic [2:0] prev);
    ebusWordT w;
    w = '0;
    w[6:8] = cur;
    w[9:11] = prev;
    @(posedge clk);
    loadBlocks <= 1'b1;
    ebusData <= w;
    @(posedge clk);
    loadBlocks <= 1'b0;
    ebusData <= '0;
    expCur = cur;
    expPrev = prev;
  endtask

  task automatic loadVma(logic usePrev);
    @(posedge clk);
    loadVmaContext <= 1'b1;
    vmaPrevEn <= usePrev;
    @(posedge clk);
    loadVmaContext <= 1'b0;
    expVma = usePrev ? expPrev : expCur;
  endtask

  function automatic fmAdrT expectAdr();
    fmAdrT a;
    a.block = expCur;
    a.adr = ac;
    case (fmSel)
      fromAcPlus1: a.adr = 4'((ac + 1) % 16);
      fromAcPlus2: a.adr = 4'((ac + 2) % 16);
      fromAcPlus3: a.adr = 4'((ac + 3) % 16);
      fromAcPlusMagic: a.adr = 4'((ac + magic[5:8]) % 16);
      fromXr: begin
        a.block = xrPrevious ? expPrev : expCur;
        a.adr = xr;
      end
      fromVma: begin
        a.block = expVma;
        a.adr = vmaLow;
      end
      fromMagic: begin
        a.block = magic[2:4];
        a.adr = magic[5:8];
      end
      default: a.adr = ac;
    endcase
    return a;
  endfunction

  task automatic resetState();
    ebusWordT w;
    diagSelT  pages[4];
    pages = '{pgFlags, pgEnables, pgBlocks, pgSummary};
    foreach (pages[i]) begin
      readPage(pages[i], w);
      checkWord($sformatf("reset %s", pages[i].name()), '0, w);
    end
    checkBit("reset interrupt", 1'b0, interrupt);
  endtask

  task automatic flagWalk();
    flagVecT m;
    conoCtlT en;
    conoCtlT clr;
    en = '{apply: 1'b1, selEn: 1'b1, default: 1'b0};
    clr = '{apply: 1'b1, selClr: 1'b1, default: 1'b0};
    for (int i = NumFlags - 1; i >= 1; i--) begin
      m = flagVecT'(8'(1) << i);
      cono(en, m);
      pulseEvents(m);
      @(negedge clk);
      checkBit($sformatf("flag %0d interrupt", i), 1'b1, interrupt);
      checkFlags($sformatf("flag %0d set", i), expFlags, pgFlags);
      cono(clr, m);
      @(negedge clk);
      checkBit($sformatf("flag %0d interrupt drop", i), 1'b0, interrupt);
      checkFlags($sformatf("flag %0d cleared", i), expFlags, pgFlags);
    end
    m = '0;
    m.sweepDone = 1'b1;
    cono(en, m);
    pulseEvents(m);
    checkFlags("sweepDone event ignored", expFlags, pgFlags);
    @(posedge clk);
    sweepBusy <= 1'b1;
    repeat (3) @(posedge clk);
    checkFlags("sweepDone while busy", expFlags, pgFlags);
    @(posedge clk);
    sweepBusy <= 1'b0;
    expFlags.sweepDone = 1'b1;
    checkFlags("sweepDone after busy falls", expFlags, pgFlags);
    checkBit("sweepDone interrupt", 1'b1, interrupt);
    cono(clr, m);
    @(negedge clk);
    checkBit("sweepDone interrupt drop", 1'b0, interrupt);
  endtask

  task automatic conoMixes();
    conoCtlT  ctl;
    flagVecT  m;
    ebusWordT w;
    ebusWordT exp;
    for (int i = 0; i < 16; i++) begin
      ctl = 5'($urandom);
      ctl.apply = (i % 4) != 3;
      m = 8'($urandom);
      if (i == 0)
        ctl = '{apply: 1'b1, selSet: 1'b1, selClr: 1'b1, default: 1'b0};
      if (i == 1)
        ctl = '{apply: 1'b1, selEn: 1'b1, selDis: 1'b1, default: 1'b0};
      cono(ctl, m);
      checkFlags($sformatf("cono %0d flags", i), expFlags, pgFlags);
      checkFlags($sformatf("cono %0d enables", i), expEnables, pgEnables);
      exp = '0;
      exp[14] = |(expFlags & expEnables);
      exp[15] = expFlags.nxmErr | expFlags.mbParErr | expFlags.sAdrParErr;
      readPage(pgSummary, w);
      checkWord($sformatf("cono %0d summary", i), exp, w);
      checkBit($sformatf("cono %0d anyEboxErr", i), exp[15], anyEboxErr);
    end
  endtask

  task automatic adrSources();
    loadBlockRegs(3'($urandom), 3'($urandom));
    loadVma(1'b1);
    for (int t = 0; t < 12; t++) begin
      for (int s = 0; s < 8; s++) begin
        @(posedge clk);
        ac <= 4'($urandom);
        xr <= 4'($urandom);
        vmaLow <= 4'($urandom);
        magic <= 9'($urandom);
        xrPrevious <= 1'($urandom);
        fmSel <= fmSelT'(s);
        @(negedge clk);
        checkFmAdr($sformatf("trial %0d %s", t, fmSel.name()), expectAdr(), fmAdr);
      end
    end
  endtask

  task automatic blockLoads();
    ebusWordT w;
    ebusWordT exp;
    for (int t = 0; t < 6; t++) begin
      loadBlockRegs(3'($urandom), 3'($urandom));
      exp = '0;
      exp[6:8] = expCur;
      exp[9:11] = expPrev;
      readPage(pgBlocks, w);
      checkWord($sformatf("blocks %0d", t), exp, w);
      loadVma(1'(t % 2));
      @(posedge clk);
      fmSel <= fromVma;
      vmaLow <= 4'($urandom);
      @(negedge clk);
      checkFmAdr($sformatf("vma block %0d", t), expectAdr(), fmAdr);
      @(posedge clk);
      fmSel <= fromXr;
      xrPrevious <= 1'(t / 2 % 2);
      @(negedge clk);
      checkFmAdr($sformatf("xr block %0d", t), expectAdr(), fmAdr);
      exp = '0;
      exp[6:8] = xrPrevious ? expPrev : expCur;
      exp[9:12] = xr;
      readPage(pgFmAdr, w);
      checkWord($sformatf("fmAdr page %0d", t), exp, w);
    end
  endtask

  task automatic parityStore();
    logic ext;
    logic par;
    @(posedge clk);
    diagRead <= 1'b0;
    fmSel <= fromMagic;
    for (int t = 0; t < 32; t++) begin
      ext = 1'($urandom);
      par = 1'($urandom);
      @(posedge clk);
      magic <= 9'($urandom);
      fmWrite <= 1'b1;
      arExtended <= ext;
      arParOdd <= par;
      @(posedge clk);
      fmWrite <= 1'b0;
      @(negedge clk);
      checkBit($sformatf("write %0d extended", t), ext, fmExtended);
      checkBit($sformatf("write %0d parity", t), par, fmBit36);
      checkWord($sformatf("write %0d idle bus", t), '0, diagData);
    end
  endtask

  initial begin
    void'($urandom(Seed));
    reset <= 1'b1;
    conoCtl <= '0;
    ebusData <= '0;
    events <= '0;
    sweepBusy <= 1'b0;
    ac <= '0;
    xr <= '0;
    vmaLow <= '0;
    magic <= '0;
    fmSel <= fromAc;
    loadBlocks <= 1'b0;
    loadVmaContext <= 1'b0;
    xrPrevious <= 1'b0;
    vmaPrevEn <= 1'b0;
    fmWrite <= 1'b0;
    arExtended <= 1'b0;
    arParOdd <= 1'b0;
    diagRead <= 1'b0;
    diagSel <= pgFlags;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    resetState();
    flagWalk();
    conoMixes();
    adrSources();
    blockLoads();
    parityStore();
    $display("Errors: word %0d, flags %0d, fmAdr %0d, bit %0d, assertion %0d",
             wordErrors, flagErrors, adrErrors, bitErrors, u_dut.u_flags.u_chk.failures);
    if (wordErrors + flagErrors + adrErrors + bitErrors + u_dut.u_flags.u_chk.failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: list.f
hdl/aprPkg.sv
hdl/aprFlags.sv
hdl/fmAddress.sv
hdl/fmParity.sv
hdl/aprDiag.sv
hdl/aprTop.sv
verif/aprFlags_chk.sv
verif/aprTb.sv

// File: Bender.yml
package:
  name: apr_status

sources:
  - files:
      - hdl/aprPkg.sv
      - hdl/aprFlags.sv
      - hdl/fmAddress.sv
      - hdl/fmParity.sv
      - hdl/aprDiag.sv
      - hdl/aprTop.sv
  - target: test
    files:
      - verif/aprFlags_chk.sv
      - verif/aprTb.sv
